/* list.f */
+incdir+tests
verilog/lsq_pkg.sv
verilog/store_forward.sv
verilog/store_queue.sv
verilog/load_queue.sv
verilog/lsq_top.sv
tests/lsq_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing --assert -f list.f --top-module lsq_tb -o lsq_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/lsq_sim > sim.log 2>&1
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && { echo "simulation failed"; exit 1; } \
	|| grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || { echo "simulation ended early"; exit 1; }

/* tests/lsq_model.svh */
// reference model for the load/store queue testbench
// program-order list, committed memory and expected load values

`ifndef LSQ_MODEL_SVH
`define LSQ_MODEL_SVH

// one uncommitted op in program order, the testbench rob
typedef struct {
	logic     is_store;
	rob_idx_t rob;
	data_t    addr;
	data_t    data;        // store data, or expected load value
	logic     done;        // load result seen
	int       waits;       // tags still to broadcast
	int       ready;       // cycle of the last operand
} op_t;

op_t   prog [$];
data_t mem_model [0:7];    // committed stores only

function automatic int slot(input data_t addr);
	return int'((addr - 64'h1000) >> 3) & 7;
endfunction

// fill pattern over the whole address
function automatic data_t fill_word(input data_t addr);
	return (addr * 64'h9e37_79b9_7f4a_7c15) ^ 64'h5a5a_0000_c3c3_0000;
endfunction

// youngest older store to the same address, else memory at dispatch
function automatic data_t expect_load(input data_t addr);
	for (int i = prog.size() - 1; i >= 0; i--)
		if (prog[i].is_store && prog[i].addr == addr)
			return prog[i].data;
	return mem_model[slot(addr)];
endfunction

// a read is legal only for a live load with no older store to that address
function automatic logic read_allowed(input data_t addr);
	logic blocked;
	blocked = 1'b0;
	foreach (prog[i]) begin
		if (prog[i].is_store && prog[i].addr == addr)
			blocked = 1'b1;
		else if (!prog[i].is_store && !prog[i].done && prog[i].addr == addr && !blocked)
			return 1'b1;
	end
	return 1'b0;
endfunction

function automatic int find_op(input rob_idx_t rob);
	foreach (prog[i])
		if (prog[i].rob == rob)
			return i;
	return -1;
endfunction

`endif

/* tests/lsq_tb.sv */
// load/store queue testbench
// random loads, stores, broadcasts and flushes against the program-order model

`timescale 1ns/1ns

module lsq_tb import lsq_pkg::*;;

	localparam int N_OPS = 400;
	localparam int LIMIT = N_OPS * 40 + 1000;    // cycles before giving up

	logic clock = 1'b0, reset;
	lsq_op_e dispatch_op;
	data_t dispatch_base, dispatch_offset, dispatch_store_data, cdb_value, mem_resp_data;
	logic dispatch_offset_valid, dispatch_store_data_valid, cdb_valid, mem_resp_valid;
	prf_tag_t dispatch_dest_tag, cdb_tag, result_tag;
	rob_idx_t dispatch_rob_idx, commit_rob_idx;
	logic commit_valid, mispredict, mem_load_valid, mem_store_valid, result_valid;
	logic [2:0] mem_load_tag, mem_resp_tag;
	data_t mem_load_addr, mem_store_addr, mem_store_data, result_value;
	logic lq_full, sq_full;

	`include "lsq_model.svh"

	typedef struct { prf_tag_t tag; data_t value; int due; rob_idx_t rob; } bcast_t;
	typedef struct { logic [2:0] tag; data_t addr; int due; } mem_req_t;
	typedef struct { data_t addr; data_t data; int due; } store_wr_t;

	bcast_t    bcast [$];      // pending cdb broadcasts
	mem_req_t  reads [$];      // outstanding memory reads
	store_wr_t writes [$];     // expected store writes
	data_t     dram [0:7];
	logic [31:0] xs = 32'd48894;
	int cycle = 0, errors = 0, checks = 0, n_disp = 0, flushes = 0;
	rob_idx_t rob_ctr = '0;
	prf_tag_t tag_ctr = '0;

	lsq_top #(.LQ_SIZE(8), .SQ_SIZE(8)) u_dut (.*);

	always #5 clock = ~clock;

	function automatic logic [31:0] next_rand();
		xs = xs ^ (xs << 13);
		xs = xs ^ (xs >> 17);
		xs = xs ^ (xs << 5);
		return xs;
	endfunction

	task automatic check(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	// one operand, as a value or as a tag broadcast 0 to 4 cycles later
	task automatic operand(input data_t value, output data_t port, output logic valid,
			inout op_t op);
		bcast_t b;
		valid = next_rand() % 2;
		port = value;
		if (!valid) begin
			b = '{tag: tag_ctr, value: value, due: cycle + int'(next_rand() % 5), rob: op.rob};
			bcast.push_back(b);
			port = data_t'(tag_ctr);
			tag_ctr++;
			op.waits++;
		end
	endtask

	always @(posedge clock) begin
		op_t op;
		data_t base, off, sdata;
		logic off_v, data_v;
		int idx;
		if (reset) begin
			// registers hold their reset values from the first edge on
			if (cycle > 0) begin
				check("result_valid", result_valid, 0);
				check("mem_load_valid", mem_load_valid, 0);
				check("mem_store_valid", mem_store_valid, 0);
				check("lq_full", lq_full, 0);
				check("sq_full", sq_full, 0);
			end
		end else begin
			////////////////////////////////////////////////////////////////////
			// observe outputs from the last cycle
			// dispatch limit keeps both queues short of capacity
			check("lq_full", lq_full, 0);
			check("sq_full", sq_full, 0);
			if (mem_store_valid) begin
				if (writes.size() == 0) begin
					errors++;
					$display("store write with no committed store");
				end else begin
					check("mem_store_valid cycle", data_t'(cycle), data_t'(writes[0].due));
					check("mem_store_addr", mem_store_addr, writes[0].addr);
					check("mem_store_data", mem_store_data, writes[0].data);
					dram[slot(mem_store_addr)] = mem_store_data;
					void'(writes.pop_front());
				end
			end else if (writes.size() > 0 && writes[0].due <= cycle) begin
				errors++;
				$display("store write missing one cycle after commit");
				void'(writes.pop_front());
			end
			if (mem_load_valid) begin
				if (!read_allowed(mem_load_addr)) begin
					errors++;
					$display("memory read at %h with no load that needs it", mem_load_addr);
				end
				reads.push_back('{mem_load_tag, mem_load_addr, cycle + 1 + int'(next_rand() % 6)});
			end
			if (result_valid) begin
				idx = -1;
				foreach (prog[i])
					if (!prog[i].is_store && !prog[i].done && {1'b1, prog[i].rob} == result_tag)
						idx = i;
				if (idx < 0) begin
					errors++;
					$display("result for tag %h with no live load", result_tag);
				end else begin
					check("result_value", result_value, prog[idx].data);
					prog[idx].done = 1'b1;
				end
			end
			// defaults, all strobes low
			dispatch_op <= OP_NONE;
			cdb_valid <= 1'b0;
			commit_valid <= 1'b0;
			mispredict <= 1'b0;
			mem_resp_valid <= 1'b0;
			// memory responder, first due read answers
			idx = -1;
			foreach (reads[i])
				if (idx < 0 && reads[i].due <= cycle)
					idx = i;
			if (idx >= 0) begin
				mem_resp_valid <= 1'b1;
				mem_resp_tag <= reads[idx].tag;
				mem_resp_data <= dram[slot(reads[idx].addr)];
				reads.delete(idx);
			end
			////////////////////////////////////////////////////////////////////
			// flush, dispatch, broadcast, commit
			if (n_disp < N_OPS && next_rand() % 50 == 0) begin
				mispredict <= 1'b1;
				prog.delete();
				bcast.delete();    // flushed operands never arrive
				flushes++;
			end else begin
				if (n_disp < N_OPS && prog.size() + reads.size() < 7 && next_rand() % 4 != 0) begin
					op = '{is_store: next_rand() % 2, rob: rob_ctr, addr: 0, data: 0,
						done: 1'b0, waits: 0, ready: cycle};
					op.addr = 64'h1000 + data_t'((next_rand() % 8) * 8);
					base = {next_rand(), next_rand()};
					dispatch_base <= base;
					operand(op.addr - base, off, off_v, op);
					dispatch_offset <= off;
					dispatch_offset_valid <= off_v;
					dispatch_rob_idx <= rob_ctr;
					dispatch_dest_tag <= {1'b1, rob_ctr};
					if (op.is_store) begin
						operand({next_rand(), next_rand()}, sdata, data_v, op);
						op.data = data_v ? sdata : bcast[bcast.size() - 1].value;
						dispatch_store_data <= sdata;
						dispatch_store_data_valid <= data_v;
						dispatch_op <= OP_STORE;
					end else begin
						op.data = expect_load(op.addr);
						dispatch_op <= OP_LOAD;
					end
					prog.push_back(op);
					rob_ctr++;
					n_disp++;
				end
				idx = -1;
				foreach (bcast[i])
					if (idx < 0 && bcast[i].due <= cycle)
						idx = i;
				if (idx >= 0) begin
					cdb_valid <= 1'b1;
					cdb_tag <= bcast[idx].tag;
					cdb_value <= bcast[idx].value;
					if (find_op(bcast[idx].rob) >= 0) begin
						prog[find_op(bcast[idx].rob)].waits--;
						prog[find_op(bcast[idx].rob)].ready = cycle;
					end
					bcast.delete(idx);
				end
				if (prog.size() > 0 && !prog[0].is_store && prog[0].done)
					void'(prog.pop_front());
				else if (prog.size() > 0 && prog[0].is_store && prog[0].waits == 0
						&& cycle > prog[0].ready) begin
					commit_valid <= 1'b1;
					commit_rob_idx <= prog[0].rob;
					mem_model[slot(prog[0].addr)] = prog[0].data;
					writes.push_back('{prog[0].addr, prog[0].data, cycle + 2});
					void'(prog.pop_front());
				end
			end
		end
		cycle++;
	end

	initial begin
		reset = 1'b1;
		dispatch_op = OP_NONE;
		{dispatch_base, dispatch_offset, dispatch_store_data} = '0;
		{dispatch_offset_valid, dispatch_store_data_valid, cdb_valid} = '0;
		{dispatch_dest_tag, dispatch_rob_idx, cdb_tag, cdb_value} = '0;
		{commit_valid, commit_rob_idx, mispredict} = '0;
		{mem_resp_valid, mem_resp_tag, mem_resp_data} = '0;
		for (int i = 0; i < 8; i++) begin
			mem_model[i] = fill_word(64'h1000 + data_t'(i * 8));
			dram[i] = mem_model[i];
		end
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		while (cycle < LIMIT && !(n_disp == N_OPS && prog.size() == 0
				&& reads.size() == 0 && writes.size() == 0))
			@(posedge clock);
		if (cycle >= LIMIT) begin
			errors++;
			$display("timeout after %0d cycles with %0d ops dispatched", cycle, n_disp);
		end
		$display("checks %0d errors %0d ops %0d flushes %0d", checks, errors, n_disp, flushes);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verilog/load_queue.sv */
// load queue
// per-entry load state machine, store forwarding, tagged memory
// reads with out-of-order responses, and result port arbitration

`timescale 1ns/1ns

module load_queue import lsq_pkg::*; #(
	parameter int LQ_SIZE = 8,
	parameter int SQ_SIZE = 8,
	localparam int LQ_TAG_W = $clog2(LQ_SIZE),    // entry index is the mem tag
	localparam int PTR_W = $clog2(SQ_SIZE) + 1
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                dispatch_load,
	input  data_t               dispatch_base,
	input  data_t               dispatch_offset,
	input  logic                dispatch_offset_valid,
	input  prf_tag_t            dispatch_dest_tag,
	input  logic                cdb_valid,
	input  prf_tag_t            cdb_tag,
	input  data_t               cdb_value,
	input  data_t [SQ_SIZE-1:0] sq_addr,
	input  logic  [SQ_SIZE-1:0] sq_addr_valid,
	input  data_t [SQ_SIZE-1:0] sq_data,
	input  logic  [SQ_SIZE-1:0] sq_data_valid,
	input  logic  [SQ_SIZE-1:0] sq_entry_valid,
	input  logic  [PTR_W-1:0]   sq_head,
	input  logic  [PTR_W-1:0]   sq_tail,
	input  logic                mem_resp_valid,
	input  logic [LQ_TAG_W-1:0] mem_resp_tag,
	input  data_t               mem_resp_data,
	input  logic                mispredict,
	output logic                mem_load_valid,
	output data_t               mem_load_addr,
	output logic [LQ_TAG_W-1:0] mem_load_tag,
	output logic                result_valid,
	output prf_tag_t            result_tag,
	output data_t               result_value,
	output logic                lq_full
);

	ld_state_e        state [LQ_SIZE];
	data_t            addr [LQ_SIZE];       // base until the offset lands
	prf_tag_t         off_tag [LQ_SIZE];
	prf_tag_t         dest_tag [LQ_SIZE];
	logic [PTR_W-1:0] sq_snap [LQ_SIZE];    // age snapshot against stores
	data_t            ld_data [LQ_SIZE];
	fwd_e             fwd [LQ_SIZE];
	data_t            fwd_data [LQ_SIZE];

	logic [LQ_SIZE-1:0]  free_vec, addr_wake, issue_req, data_req, resp_vec;
	logic [LQ_SIZE-1:0]  alloc_gnt, issue_gnt, result_gnt;
	logic [LQ_TAG_W-1:0] alloc_idx, issue_idx, result_idx;
	logic                do_dispatch;
	logic                off_cdb_hit;

	// lowest set bit wins
	function automatic logic [LQ_TAG_W-1:0] lowest(input logic [LQ_SIZE-1:0] vec);
		logic [LQ_TAG_W-1:0] idx;
		idx = '0;
		for (int i = LQ_SIZE - 1; i >= 0; i--) begin
			if (vec[i])
				idx = LQ_TAG_W'(i);
		end
		return idx;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// one store search per entry

	for (genvar g = 0; g < LQ_SIZE; g++) begin : g_fwd
		store_forward #(.SQ_SIZE(SQ_SIZE)) u_store_forward (
			.load_addr      (addr[g]),
			.load_sq_tail   (sq_snap[g]),
			.sq_addr        (sq_addr),
			.sq_addr_valid  (sq_addr_valid),
			.sq_data        (sq_data),
			.sq_data_valid  (sq_data_valid),
			.sq_entry_valid (sq_entry_valid),
			.sq_head        (sq_head),
			.fwd            (fwd[g]),
			.fwd_data       (fwd_data[g])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// request vectors and arbitration

	always_comb begin
		for (int i = 0; i < LQ_SIZE; i++) begin
			free_vec[i]  = (state[i] == LD_FREE);
			addr_wake[i] = (state[i] == LD_ADDR) && cdb_valid && (off_tag[i] == cdb_tag);
			issue_req[i] = (state[i] == LD_SEARCH) && (fwd[i] == FWD_NONE);
			data_req[i]  = (state[i] == LD_DATA);
			resp_vec[i]  = mem_resp_valid && (mem_resp_tag == LQ_TAG_W'(i));
			alloc_gnt[i] = do_dispatch && free_vec[i] && (alloc_idx == LQ_TAG_W'(i));
			issue_gnt[i] = mem_load_valid && (issue_idx == LQ_TAG_W'(i));
			result_gnt[i] = result_valid && (result_idx == LQ_TAG_W'(i));
		end
	end

	assign alloc_idx  = lowest(free_vec);
	assign issue_idx  = lowest(issue_req);
	assign result_idx = lowest(data_req);
	assign lq_full = ~|free_vec;
	assign do_dispatch = dispatch_load && !mispredict;
	assign off_cdb_hit = !dispatch_offset_valid && cdb_valid
		&& (cdb_tag == dispatch_offset[PRF_TAG_W-1:0]);

	// no read or result in a flush cycle, the entry is going away
	assign mem_load_valid = |issue_req && !mispredict;
	assign mem_load_addr = addr[issue_idx];
	assign mem_load_tag = issue_idx;
	assign result_valid = |data_req && !mispredict;
	assign result_tag = dest_tag[result_idx];
	assign result_value = ld_data[result_idx];

	//////////////////////////////////////////////////////////////////////
	// entry state machine

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < LQ_SIZE; i++)
				state[i] <= LD_FREE;
		end else begin
			for (int i = 0; i < LQ_SIZE; i++) begin
				unique case (state[i])
					LD_FREE:
						if (alloc_gnt[i])
							state[i] <= (dispatch_offset_valid || off_cdb_hit) ? LD_SEARCH : LD_ADDR;
					LD_ADDR:
						if (addr_wake[i])
							state[i] <= LD_SEARCH;
					LD_SEARCH:
						if (fwd[i] == FWD_HIT)
							state[i] <= LD_DATA;
						else if (issue_gnt[i])
							state[i] <= LD_MEM;
					LD_MEM:
						if (resp_vec[i])
							state[i] <= LD_DATA;
					LD_DATA:
						if (result_gnt[i])
							state[i] <= LD_FREE;    // broadcast frees the entry
					LD_DROP:
						if (resp_vec[i])
							state[i] <= LD_FREE;    // late response swallowed
					default:
						state[i] <= LD_FREE;
				endcase
				// flush, reads still in flight must drain first
				if (mispredict)
					state[i] <= ((state[i] == LD_MEM || state[i] == LD_DROP) && !resp_vec[i])
						? LD_DROP : LD_FREE;
			end
		end
	end

	// entry payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < LQ_SIZE; i++) begin
			if (alloc_gnt[i]) begin
				if (dispatch_offset_valid)
					addr[i] <= dispatch_base + dispatch_offset;
				else if (off_cdb_hit)
					addr[i] <= dispatch_base + cdb_value;
				else
					addr[i] <= dispatch_base;
				off_tag[i] <= dispatch_offset[PRF_TAG_W-1:0];
				dest_tag[i] <= dispatch_dest_tag;
				sq_snap[i] <= sq_tail;    // stores before this are older
			end
			if (addr_wake[i])
				addr[i] <= addr[i] + cdb_value;
			if (state[i] == LD_SEARCH && fwd[i] == FWD_HIT)
				ld_data[i] <= fwd_data[i];
			else if (state[i] == LD_MEM && resp_vec[i])
				ld_data[i] <= mem_resp_data;
		end
	end

	// memory only answers reads it was given
	a_resp_target: assert property (@(posedge clock) disable iff (reset)
		mem_resp_valid |-> state[mem_resp_tag] inside {LD_MEM, LD_DROP});

	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		dispatch_load |-> !lq_full);

endmodule

/* verilog/lsq_pkg.sv */
// load/store queue shared definitions
// widths, payload types and the opcode and state encodings

package lsq_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths

	localparam int DATA_W    = 64;    // address and data word
	localparam int PRF_TAG_W = 6;     // physical register tag
	localparam int ROB_IDX_W = 5;     // reorder buffer slot

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [PRF_TAG_W-1:0] prf_tag_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;

	//////////////////////////////////////////////////////////////////////
	// encodings

	// dispatch opcode, one op per cycle
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_LOAD  = 2'd1,
		OP_STORE = 2'd2
	} lsq_op_e;

	// load entry life cycle
	typedef enum logic [2:0] {
		LD_FREE   = 3'd0,    // empty
		LD_ADDR   = 3'd1,    // offset tag not yet broadcast
		LD_SEARCH = 3'd2,    // address known, checking older stores
		LD_MEM    = 3'd3,    // read outstanding
		LD_DATA   = 3'd4,    // data held, waiting for the result port
		LD_DROP   = 3'd5     // flushed with a read in flight
	} ld_state_e;

	// store search outcome for one load
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,    // no older match, go to memory
		FWD_HIT  = 2'd1,    // forwarded data valid
		FWD_WAIT = 2'd2     // unknown address or data, retry
	} fwd_e;

endpackage

/* verilog/lsq_top.sv */
// load/store queue top level
// splits dispatch between the store and load queues and
// routes the store view from one to the other

`timescale 1ns/1ns

module lsq_top import lsq_pkg::*; #(
	parameter int LQ_SIZE = 8,
	parameter int SQ_SIZE = 8,
	localparam int LQ_TAG_W = $clog2(LQ_SIZE),
	localparam int PTR_W = $clog2(SQ_SIZE) + 1
) (
	input  logic                clock,
	input  logic                reset,
	// dispatch
	input  lsq_op_e             dispatch_op,
	input  data_t               dispatch_base,
	input  data_t               dispatch_offset,          // value, or tag in low bits
	input  logic                dispatch_offset_valid,
	input  data_t               dispatch_store_data,
	input  logic                dispatch_store_data_valid,
	input  prf_tag_t            dispatch_dest_tag,
	input  rob_idx_t            dispatch_rob_idx,
	// common data bus
	input  logic                cdb_valid,
	input  prf_tag_t            cdb_tag,
	input  data_t               cdb_value,
	// memory
	output logic                mem_load_valid,
	output data_t               mem_load_addr,
	output logic [LQ_TAG_W-1:0] mem_load_tag,
	input  logic                mem_resp_valid,
	input  logic [LQ_TAG_W-1:0] mem_resp_tag,
	input  data_t               mem_resp_data,
	output logic                mem_store_valid,
	output data_t               mem_store_addr,
	output data_t               mem_store_data,
	// rob side
	input  logic                commit_valid,
	input  rob_idx_t            commit_rob_idx,
	input  logic                mispredict,
	// load result
	output logic                result_valid,
	output prf_tag_t            result_tag,
	output data_t               result_value,
	output logic                lq_full,
	output logic                sq_full
);

	// store view, sq to lq
	data_t [SQ_SIZE-1:0] sq_addr;
	data_t [SQ_SIZE-1:0] sq_data;
	logic  [SQ_SIZE-1:0] sq_addr_valid;
	logic  [SQ_SIZE-1:0] sq_data_valid;
	logic  [SQ_SIZE-1:0] sq_entry_valid;
	logic  [PTR_W-1:0]   sq_head;
	logic  [PTR_W-1:0]   sq_tail;
	logic                dispatch_load;
	logic                dispatch_store;

	assign dispatch_load  = (dispatch_op == OP_LOAD);    // opcode decode
	assign dispatch_store = (dispatch_op == OP_STORE);

	store_queue #(.SQ_SIZE(SQ_SIZE)) u_store_queue (.*);

	load_queue #(.LQ_SIZE(LQ_SIZE), .SQ_SIZE(SQ_SIZE)) u_load_queue (.*);

endmodule

/* verilog/store_forward.sv */
// store search for one load
// walks from the youngest older store back to the head and
// reports forward, wait, or go to memory

`timescale 1ns/1ns

module store_forward import lsq_pkg::*; #(
	parameter int SQ_SIZE = 8,
	localparam int PTR_W = $clog2(SQ_SIZE) + 1
) (
	input  data_t               load_addr,
	input  logic  [PTR_W-1:0]   load_sq_tail,     // sq tail at load dispatch
	input  data_t [SQ_SIZE-1:0] sq_addr,
	input  logic  [SQ_SIZE-1:0] sq_addr_valid,
	input  data_t [SQ_SIZE-1:0] sq_data,
	input  logic  [SQ_SIZE-1:0] sq_data_valid,
	input  logic  [SQ_SIZE-1:0] sq_entry_valid,
	input  logic  [PTR_W-1:0]   sq_head,
	output fwd_e                fwd,
	output data_t               fwd_data
);

	localparam int IDX_W = PTR_W - 1;

	logic [PTR_W-1:0] older_cnt;    // stores between head and snapshot
	logic [IDX_W-1:0] idx;
	logic             done;         // search settled

	assign older_cnt = load_sq_tail - sq_head;

	// youngest first, stop at the first unknown or matching address
	always_comb begin
		fwd = FWD_NONE;
		fwd_data = '0;
		done = 1'b0;
		idx = '0;
		for (int k = 0; k < SQ_SIZE; k++) begin
			idx = load_sq_tail[IDX_W-1:0] - IDX_W'(k + 1);
			if (!done && (PTR_W'(k) < older_cnt) && sq_entry_valid[idx]) begin
				if (!sq_addr_valid[idx]) begin
					fwd = FWD_WAIT;    // could alias, hold off
					done = 1'b1;
				end else if (sq_addr[idx] == load_addr) begin
					fwd = sq_data_valid[idx] ? FWD_HIT : FWD_WAIT;
					fwd_data = sq_data[idx];
					done = 1'b1;
				end
			end
		end
	end

endmodule

/* verilog/store_queue.sv */
// store queue
// program-order store buffer, operands woken by the data bus,
// head written to memory on commit, flushed back to head on mispredict

`timescale 1ns/1ns

module store_queue import lsq_pkg::*; #(
	parameter int SQ_SIZE = 8,
	localparam int PTR_W = $clog2(SQ_SIZE) + 1    // one wrap bit
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                dispatch_store,
	input  data_t               dispatch_base,
	input  data_t               dispatch_offset,
	input  logic                dispatch_offset_valid,
	input  data_t               dispatch_store_data,
	input  logic                dispatch_store_data_valid,
	input  rob_idx_t            dispatch_rob_idx,
	input  logic                cdb_valid,
	input  prf_tag_t            cdb_tag,
	input  data_t               cdb_value,
	input  logic                commit_valid,
	input  rob_idx_t            commit_rob_idx,
	input  logic                mispredict,
	output data_t [SQ_SIZE-1:0] sq_addr,          // base until the offset lands
	output logic  [SQ_SIZE-1:0] sq_addr_valid,
	output data_t [SQ_SIZE-1:0] sq_data,          // tag in low bits until valid
	output logic  [SQ_SIZE-1:0] sq_data_valid,
	output logic  [SQ_SIZE-1:0] sq_entry_valid,
	output logic  [PTR_W-1:0]   sq_head,
	output logic  [PTR_W-1:0]   sq_tail,
	output logic                mem_store_valid,
	output data_t               mem_store_addr,
	output data_t               mem_store_data,
	output logic                sq_full
);

	localparam int IDX_W = PTR_W - 1;

	prf_tag_t [SQ_SIZE-1:0] off_tag;      // offset tag per entry
	rob_idx_t [SQ_SIZE-1:0] rob_idx;
	logic     [SQ_SIZE-1:0] addr_wake;    // offset broadcast this cycle
	logic     [SQ_SIZE-1:0] data_wake;
	logic     [IDX_W-1:0]   head_idx;
	logic     [IDX_W-1:0]   tail_idx;
	logic     [PTR_W-1:0]   head_next;
	logic                   do_dispatch;
	logic                   commit_hit;
	logic                   off_cdb_hit;    // operand on the bus in the dispatch cycle
	logic                   data_cdb_hit;

	assign head_idx = sq_head[IDX_W-1:0];
	assign tail_idx = sq_tail[IDX_W-1:0];
	assign sq_full = (head_idx == tail_idx) && (sq_head[IDX_W] != sq_tail[IDX_W]);
	assign do_dispatch = dispatch_store && !mispredict;    // dropped on flush
	assign commit_hit = commit_valid && sq_entry_valid[head_idx]
		&& (rob_idx[head_idx] == commit_rob_idx);
	assign head_next = commit_hit ? sq_head + 1'b1 : sq_head;

	assign off_cdb_hit = !dispatch_offset_valid && cdb_valid
		&& (cdb_tag == dispatch_offset[PRF_TAG_W-1:0]);
	assign data_cdb_hit = !dispatch_store_data_valid && cdb_valid
		&& (cdb_tag == dispatch_store_data[PRF_TAG_W-1:0]);

	// tag match against waiting entries
	always_comb begin
		for (int i = 0; i < SQ_SIZE; i++) begin
			addr_wake[i] = cdb_valid && sq_entry_valid[i] && !sq_addr_valid[i]
				&& (off_tag[i] == cdb_tag);
			data_wake[i] = cdb_valid && sq_entry_valid[i] && !sq_data_valid[i]
				&& (sq_data[i][PRF_TAG_W-1:0] == cdb_tag);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// pointers and flags

	always_ff @(posedge clock) begin
		if (reset) begin
			sq_head <= '0;
			sq_tail <= '0;
			sq_entry_valid <= '0;
			sq_addr_valid <= '0;
			sq_data_valid <= '0;
			mem_store_valid <= 1'b0;
		end else begin
			mem_store_valid <= commit_hit;    // one cycle after commit
			sq_head <= head_next;
			sq_addr_valid <= sq_addr_valid | addr_wake;
			sq_data_valid <= sq_data_valid | data_wake;
			if (commit_hit)
				sq_entry_valid[head_idx] <= 1'b0;
			if (mispredict) begin
				sq_tail <= head_next;    // everything uncommitted goes
				sq_entry_valid <= '0;
			end else if (do_dispatch) begin
				sq_tail <= sq_tail + 1'b1;
				sq_entry_valid[tail_idx] <= 1'b1;
				sq_addr_valid[tail_idx] <= dispatch_offset_valid || off_cdb_hit;
				sq_data_valid[tail_idx] <= dispatch_store_data_valid || data_cdb_hit;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// entry payload and store write

	always_ff @(posedge clock) begin
		if (commit_hit) begin
			mem_store_addr <= sq_addr[head_idx];
			mem_store_data <= sq_data[head_idx];
		end
		for (int i = 0; i < SQ_SIZE; i++) begin
			if (addr_wake[i])
				sq_addr[i] <= sq_addr[i] + cdb_value;    // base + offset
			if (data_wake[i])
				sq_data[i] <= cdb_value;
		end
		if (do_dispatch) begin
			if (dispatch_offset_valid)
				sq_addr[tail_idx] <= dispatch_base + dispatch_offset;
			else if (off_cdb_hit)
				sq_addr[tail_idx] <= dispatch_base + cdb_value;
			else
				sq_addr[tail_idx] <= dispatch_base;    // hold base, add later
			sq_data[tail_idx] <= data_cdb_hit ? cdb_value : dispatch_store_data;
			off_tag[tail_idx] <= dispatch_offset[PRF_TAG_W-1:0];
			rob_idx[tail_idx] <= dispatch_rob_idx;
		end
	end

	// rob only commits the head store, once both operands were broadcast
	a_commit_ready: assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> commit_hit && sq_addr_valid[head_idx] && sq_data_valid[head_idx]);

	// dispatch holds off while full
	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		dispatch_store |-> !sq_full);

endmodule
